/* design/shell_settings.svh */
// Widths, depths and reset constants of the core shell
// Capability encodings and scramble defaults

`ifndef SHELL_SETTINGS_SVH
`define SHELL_SETTINGS_SVH

////////////////////
// Register file
////////////////////

`define RF_DATA_W   91
`define RF_ADDR_W   5
`define RF_NUM_REGS 32

// Full-permission capability held by every entry after reset
`define CAP_ALMIGHTY 91'h40000000003FFDF690003F0
// No-permission capability read from x0
`define CAP_NULL     91'h00000000000001F690003F0

////////////////////
// Scramble key
////////////////////

`define SCR_KEY_W   128
`define SCR_NONCE_W 64

`define SCR_KEY_DEFAULT   128'h14E8_F0A2_77C3_5B91_0D6E_A4F2_C83B_1975
`define SCR_NONCE_DEFAULT 64'hF9D1_2B6C_84A0_E357

`endif

/* design/shell_pkg.sv */
// Shared types of the core shell
// Register file address and word, key manager states

`include "shell_settings.svh"

package shell_pkg;

  // Register index
  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

  // One capability word
  typedef logic [`RF_DATA_W-1:0] rf_word_t;

  // Scramble key manager
  typedef enum logic {
    KEY_VALID = 1'b0,
    KEY_REQ   = 1'b1
  } key_state_e;

endpackage

/* design/sleep_ctrl.sv */
// Core sleep control
// Busy register, wake enable and clock gate for the core clock domain

`timescale 1ns/1ns

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clk_gated_o,
  output logic core_sleep_o
);

  logic core_busy_q;
  logic clock_en;
  logic en_latch;

  ////////////////////
  // Wake enable
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the clock running
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  ////////////////////
  // Clock gate
  ////////////////////

  // Transparent while the clock is low, so the enable is stable over the high phase
  always_latch begin
    if (!clk_i) begin
      en_latch = clock_en | test_en_i;
    end
  end

  assign clk_gated_o = clk_i & en_latch;

  // Gated clock only rises with clk_i, never in the middle of a high phase
  a_gate_glitch_free: assert property (
    @(posedge clk_gated_o) disable iff (!rst_ni)
    !clk_i
  ) else $error("gated clock rose while clk_i was already high");

endmodule

/* design/key_mgr_fsm.sv */
// Scramble key manager
// Key request FSM and the key and nonce registers

`timescale 1ns/1ns

`include "shell_settings.svh"

module key_mgr_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    icache_inval_i,
  input  logic                    scramble_key_valid_i,
  input  logic [`SCR_KEY_W-1:0]   scramble_key_i,
  input  logic [`SCR_NONCE_W-1:0] scramble_nonce_i,
  output logic                    scramble_req_o,
  output logic                    scr_key_valid_o,
  output logic [`SCR_KEY_W-1:0]   scr_key_o,
  output logic [`SCR_NONCE_W-1:0] scr_nonce_o
);

  shell_pkg::key_state_e state_d;
  shell_pkg::key_state_e state_q;

  logic [`SCR_KEY_W-1:0]   key_q;
  logic [`SCR_NONCE_W-1:0] nonce_q;

  ////////////////////
  // Request FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      shell_pkg::KEY_VALID: begin
        // Old key must not be reused after a cache invalidate
        if (icache_inval_i) begin
          state_d = shell_pkg::KEY_REQ;
        end
      end
      shell_pkg::KEY_REQ: begin
        // Further invalidates are ignored here
        if (scramble_key_valid_i) begin
          state_d = shell_pkg::KEY_VALID;
        end
      end
      default: state_d = shell_pkg::KEY_VALID;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= shell_pkg::KEY_VALID;
    end else begin
      state_q <= state_d;
    end
  end

  assign scramble_req_o  = (state_q == shell_pkg::KEY_REQ);
  assign scr_key_valid_o = (state_q == shell_pkg::KEY_VALID);

  ////////////////////
  // Key and nonce
  ////////////////////

  // Any valid key from the provider is captured, whatever the state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= `SCR_KEY_DEFAULT;
      nonce_q <= `SCR_NONCE_DEFAULT;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign scr_key_o   = key_q;
  assign scr_nonce_o = nonce_q;

  // Key valid only returns once a new key has arrived
  a_key_return: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(scr_key_valid_o) |-> $past(scramble_key_valid_i)
  ) else $error("key valid returned without a new key");

  a_inval_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (scr_key_valid_o && icache_inval_i) |=> scramble_req_o
  ) else $error("invalidate not followed by a key request");

endmodule

/* design/regfile_ff.sv */
// Flip-flop register file of capability words
// Entry zero reads the null capability and the rest reset to almighty
// Write-enable decode check raises an error flag

`timescale 1ns/1ns

`include "shell_settings.svh"

module regfile_ff (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  shell_pkg::rf_addr_t raddr_a_i,
  input  shell_pkg::rf_addr_t raddr_b_i,
  input  shell_pkg::rf_addr_t waddr_i,
  input  shell_pkg::rf_word_t wdata_i,
  input  logic                we_i,
  output shell_pkg::rf_word_t rdata_a_o,
  output shell_pkg::rf_word_t rdata_b_o,
  output logic                err_o
);

  logic [`RF_NUM_REGS-1:0] we_dec;
  logic                    we_multi;
  logic                    we_stray;

  shell_pkg::rf_word_t rf_q   [1:`RF_NUM_REGS-1];
  shell_pkg::rf_word_t rf_all [`RF_NUM_REGS];

  ////////////////////
  // Write decode
  ////////////////////

  // x0 is never written, so bit 0 stays clear
  always_comb begin
    we_dec = '0;
    for (int i = 1; i < `RF_NUM_REGS; i++) begin
      we_dec[i] = we_i && (waddr_i == shell_pkg::rf_addr_t'(i));
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  for (genvar i = 1; i < `RF_NUM_REGS; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= `CAP_ALMIGHTY;
      end else if (we_dec[i]) begin
        rf_q[i] <= wdata_i;
      end
    end
  end

  // Full read view with x0 hard-wired
  always_comb begin
    rf_all[0] = `CAP_NULL;
    for (int i = 1; i < `RF_NUM_REGS; i++) begin
      rf_all[i] = rf_q[i];
    end
  end

  assign rdata_a_o = rf_all[raddr_a_i];
  assign rdata_b_o = rf_all[raddr_b_i];

  ////////////////////
  // Glitch check
  ////////////////////

  // More than one enable set at once
  assign we_multi = |(we_dec & (we_dec - 1'b1));

  // Enable set with no write requested
  assign we_stray = (|we_dec) & ~we_i;

  assign err_o = we_multi | we_stray;

  // Only the addressed entry is enabled, never x0
  a_we_decode: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    we_dec == ((we_i && waddr_i != '0) ? (`RF_NUM_REGS'(1) << waddr_i) : '0)
  ) else $error("register file write enable decode wrong");

  // A write to a nonzero address shows up on the next gated edge
  a_write_lands: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (we_i && waddr_i != '0) |=> (rf_all[$past(waddr_i)] == $past(wdata_i))
  ) else $error("register file write lost while clock running");

endmodule

/* design/core_shell_top.sv */
// Top level of the core shell
// Sleep control, register file, scramble key manager and alert combining

`timescale 1ns/1ns

`include "shell_settings.svh"

module core_shell_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    test_en_i,

  // Wake sources
  input  logic                    core_busy_i,
  input  logic                    debug_req_i,
  input  logic                    irq_pending_i,
  input  logic                    irq_nm_i,
  output logic                    core_sleep_o,

  // Register file access from the core
  input  shell_pkg::rf_addr_t     rf_raddr_a_i,
  input  shell_pkg::rf_addr_t     rf_raddr_b_i,
  input  shell_pkg::rf_addr_t     rf_waddr_i,
  input  shell_pkg::rf_word_t     rf_wdata_i,
  input  logic                    rf_we_i,
  output shell_pkg::rf_word_t     rf_rdata_a_o,
  output shell_pkg::rf_word_t     rf_rdata_b_o,

  // Scramble key interface
  input  logic                    icache_inval_i,
  input  logic                    scramble_key_valid_i,
  input  logic [`SCR_KEY_W-1:0]   scramble_key_i,
  input  logic [`SCR_NONCE_W-1:0] scramble_nonce_i,
  output logic                    scramble_req_o,
  output logic                    scr_key_valid_o,
  output logic [`SCR_KEY_W-1:0]   scr_key_o,
  output logic [`SCR_NONCE_W-1:0] scr_nonce_o,

  // Alerts
  input  logic                    alert_minor_core_i,
  input  logic                    alert_major_internal_core_i,
  input  logic                    alert_major_bus_core_i,
  output logic                    alert_minor_o,
  output logic                    alert_major_internal_o,
  output logic                    alert_major_bus_o
);

  logic clk_gated;
  logic rf_err;

  sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .clk_gated_o  (clk_gated),
    .core_sleep_o (core_sleep_o)
  );

  // Register file sits in the gated domain
  regfile_ff u_regfile (
    .clk_i    (clk_gated),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .we_i     (rf_we_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o),
    .err_o    (rf_err)
  );

  key_mgr_fsm u_key_mgr (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .scr_key_valid_o     (scr_key_valid_o),
    .scr_key_o           (scr_key_o),
    .scr_nonce_o         (scr_nonce_o)
  );

  ////////////////////
  // Alerts
  ////////////////////

  // Write-enable glitch counts as a major internal fault
  assign alert_major_internal_o = alert_major_internal_core_i | rf_err;
  assign alert_major_bus_o      = alert_major_bus_core_i;
  assign alert_minor_o          = alert_minor_core_i;

endmodule

/* sim/tb_core_shell.sv */
// Testbench for the core shell top level
// LFSR stimulus, register file and key manager model, checking assertions

`timescale 1ns/1ns

`include "shell_settings.svh"

module tb_core_shell;

  logic                    clk;
  logic                    rst_n;
  logic                    test_en;
  logic                    core_busy;
  logic                    debug_req;
  logic                    irq_pending;
  logic                    irq_nm;
  logic                    core_sleep;
  shell_pkg::rf_addr_t     rf_raddr_a;
  shell_pkg::rf_addr_t     rf_raddr_b;
  shell_pkg::rf_addr_t     rf_waddr;
  shell_pkg::rf_word_t     rf_wdata;
  logic                    rf_we;
  shell_pkg::rf_word_t     rf_rdata_a;
  shell_pkg::rf_word_t     rf_rdata_b;
  logic                    icache_inval;
  logic                    key_valid_in;
  logic [`SCR_KEY_W-1:0]   key_in;
  logic [`SCR_NONCE_W-1:0] nonce_in;
  logic                    scramble_req;
  logic                    scr_key_valid;
  logic [`SCR_KEY_W-1:0]   scr_key;
  logic [`SCR_NONCE_W-1:0] scr_nonce;
  logic                    alert_minor_in;
  logic                    alert_internal_in;
  logic                    alert_bus_in;
  logic                    alert_minor;
  logic                    alert_internal;
  logic                    alert_bus;

  logic [15:0] lfsr_q;

  // Reference model state
  logic                    busy_m;
  logic                    any_wake_in;
  logic                    wake_m;
  logic                    req_m;
  logic [`SCR_KEY_W-1:0]   key_m;
  logic [`SCR_NONCE_W-1:0] nonce_m;
  shell_pkg::rf_word_t     shadow_q [`RF_NUM_REGS];
  shell_pkg::rf_word_t     exp_a;
  shell_pkg::rf_word_t     exp_b;

  core_shell_top dut0 (
    .clk_i                      (clk),
    .rst_ni                     (rst_n),
    .test_en_i                  (test_en),
    .core_busy_i                (core_busy),
    .debug_req_i                (debug_req),
    .irq_pending_i              (irq_pending),
    .irq_nm_i                   (irq_nm),
    .core_sleep_o               (core_sleep),
    .rf_raddr_a_i               (rf_raddr_a),
    .rf_raddr_b_i               (rf_raddr_b),
    .rf_waddr_i                 (rf_waddr),
    .rf_wdata_i                 (rf_wdata),
    .rf_we_i                    (rf_we),
    .rf_rdata_a_o               (rf_rdata_a),
    .rf_rdata_b_o               (rf_rdata_b),
    .icache_inval_i             (icache_inval),
    .scramble_key_valid_i       (key_valid_in),
    .scramble_key_i             (key_in),
    .scramble_nonce_i           (nonce_in),
    .scramble_req_o             (scramble_req),
    .scr_key_valid_o            (scr_key_valid),
    .scr_key_o                  (scr_key),
    .scr_nonce_o                (scr_nonce),
    .alert_minor_core_i         (alert_minor_in),
    .alert_major_internal_core_i(alert_internal_in),
    .alert_major_bus_core_i     (alert_bus_in),
    .alert_minor_o              (alert_minor),
    .alert_major_internal_o     (alert_internal),
    .alert_major_bus_o          (alert_bus)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  assign any_wake_in = debug_req | irq_pending | irq_nm;
  assign wake_m      = busy_m | any_wake_in;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_m  <= 1'b0;
      req_m   <= 1'b0;
      key_m   <= `SCR_KEY_DEFAULT;
      nonce_m <= `SCR_NONCE_DEFAULT;
      for (int i = 0; i < `RF_NUM_REGS; i++) begin
        shadow_q[i] <= `CAP_ALMIGHTY;
      end
    end else begin
      busy_m <= core_busy;
      // Writes only land while the core clock runs
      if (wake_m && rf_we && rf_waddr != '0) begin
        shadow_q[rf_waddr] <= rf_wdata;
      end
      if (!req_m && icache_inval) begin
        req_m <= 1'b1;
      end else if (req_m && key_valid_in) begin
        req_m <= 1'b0;
      end
      if (key_valid_in) begin
        key_m   <= key_in;
        nonce_m <= nonce_in;
      end
    end
  end

  assign exp_a = (rf_raddr_a == '0) ? `CAP_NULL : shadow_q[rf_raddr_a];
  assign exp_b = (rf_raddr_b == '0) ? `CAP_NULL : shadow_q[rf_raddr_b];

  ////////////////////
  // Failure reporting
  ////////////////////

  task automatic abort_run(input string detail);
    $display(">>> FAIL");
    $display("%s", detail);
    $fatal(1);
  endtask

  task automatic value_error(input string msg);
    abort_run($sformatf("FAIL %0t ns: %s", $time, msg));
  endtask

  ////////////////////
  // Checks
  ////////////////////

  a_read_a: assert property (@(posedge clk) disable iff (!rst_n) rf_rdata_a == exp_a)
    else value_error($sformatf("port A addr %0d read %h", rf_raddr_a, rf_rdata_a));
  a_read_b: assert property (@(posedge clk) disable iff (!rst_n) rf_rdata_b == exp_b)
    else value_error($sformatf("port B addr %0d read %h", rf_raddr_b, rf_rdata_b));
  a_x0_null: assert property (@(posedge clk) disable iff (!rst_n)
    (rf_raddr_a != '0 || rf_rdata_a == `CAP_NULL) && (rf_raddr_b != '0 || rf_rdata_b == `CAP_NULL))
    else value_error("x0 does not read the null capability");
  a_sleep_level: assert property (@(posedge clk) disable iff (!rst_n) core_sleep == !wake_m)
    else value_error("core_sleep_o differs from the wake rule");
  a_sleep_entry: assert property (@(posedge clk) disable iff (!rst_n)
    (!core_busy && !any_wake_in) |=> (any_wake_in || core_sleep))
    else value_error("core did not sleep one cycle after busy fell");
  a_wake_now: assert property (@(posedge clk) disable iff (!rst_n) any_wake_in |-> !core_sleep)
    else value_error("wake input did not clear core_sleep_o");
  a_key_state: assert property (@(posedge clk) disable iff (!rst_n)
    scramble_req == req_m && scr_key_valid == !req_m)
    else value_error("request or key valid differs from the key state");
  a_inval_req: assert property (@(posedge clk) disable iff (!rst_n)
    (!req_m && icache_inval) |=> (scramble_req && !scr_key_valid))
    else value_error("invalidate did not request a new key");
  a_key_return: assert property (@(posedge clk) disable iff (!rst_n)
    (req_m && key_valid_in) |=> (!scramble_req && scr_key_valid))
    else value_error("new key did not end the request");
  a_key_data: assert property (@(posedge clk) disable iff (!rst_n)
    scr_key == key_m && scr_nonce == nonce_m)
    else value_error($sformatf("key %h nonce %h", scr_key, scr_nonce));
  a_alerts: assert property (@(posedge clk) disable iff (!rst_n)
    alert_minor == alert_minor_in && alert_internal == alert_internal_in &&
    alert_bus == alert_bus_in)
    else value_error("alert output differs from core alert input");

  ////////////////////
  // Stimulus
  ////////////////////

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic random_access(input int cycles);
    logic [127:0] r;
    for (int c = 0; c < cycles; c++) begin
      next_cycle();
      random_bits(1, r);
      rf_we = r[0];
      random_bits(5, r);
      rf_waddr = r[4:0];
      random_bits(91, r);
      rf_wdata = r[90:0];
      random_bits(10, r);
      rf_raddr_a = r[4:0];
      rf_raddr_b = r[9:5];
      random_bits(3, r);
      alert_minor_in    = r[0];
      alert_internal_in = r[1];
      alert_bus_in      = r[2];
      // Regular attempts on x0
      if (c % 8 == 7) begin
        rf_we    = 1'b1;
        rf_waddr = '0;
      end
    end
  endtask

  task automatic read_sweep();
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      next_cycle();
      rf_we      = 1'b0;
      rf_raddr_a = shell_pkg::rf_addr_t'(i);
      rf_raddr_b = shell_pkg::rf_addr_t'(`RF_NUM_REGS - 1 - i);
    end
  endtask

  task automatic wait_for_sleep(input logic level, input int limit);
    int n;
    n = 0;
    while (core_sleep != level) begin
      if (n == limit) begin
        abort_run("core_sleep_o did not reach the expected level in time");
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic wait_for_key_req(input logic level, input int limit);
    int n;
    n = 0;
    while (scramble_req != level) begin
      if (n == limit) begin
        abort_run("scramble_req_o did not reach the expected level in time");
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic wake_burst(input logic [2:0] src);
    next_cycle();
    {irq_nm, debug_req, irq_pending} = src;
    random_access(4);
    next_cycle();
    {irq_nm, debug_req, irq_pending} = 3'b000;
    rf_we = 1'b0;
    wait_for_sleep(1'b1, 8);
  endtask

  task automatic key_exchange();
    logic [127:0] r;
    next_cycle();
    icache_inval = 1'b1;
    next_cycle();
    icache_inval = 1'b0;
    wait_for_key_req(1'b1, 8);
    // Second invalidate while waiting has no effect
    next_cycle();
    icache_inval = 1'b1;
    next_cycle();
    icache_inval = 1'b0;
    random_bits(128, r);
    key_in = r;
    random_bits(64, r);
    nonce_in = r[63:0];
    key_valid_in = 1'b1;
    next_cycle();
    key_valid_in = 1'b0;
    wait_for_key_req(1'b0, 8);
  endtask

  initial begin
    rst_n = 1'b1;
    test_en = 1'b0;
    core_busy = 1'b0;
    debug_req = 1'b0;
    irq_pending = 1'b0;
    irq_nm = 1'b0;
    rf_raddr_a = '0;
    rf_raddr_b = '0;
    rf_waddr = '0;
    rf_wdata = '0;
    rf_we = 1'b0;
    icache_inval = 1'b0;
    key_valid_in = 1'b0;
    key_in = '0;
    nonce_in = '0;
    alert_minor_in = 1'b0;
    alert_internal_in = 1'b0;
    alert_bus_in = 1'b0;
    lfsr_q = 16'd15565;
    #1 rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    read_sweep();
    next_cycle();
    core_busy = 1'b1;
    random_access(200);
    read_sweep();

    // Sleep and the three wake sources
    next_cycle();
    core_busy = 1'b0;
    rf_we = 1'b0;
    wait_for_sleep(1'b1, 8);
    random_access(16);
    read_sweep();
    wake_burst(3'b100);
    wake_burst(3'b010);
    wake_burst(3'b001);
    read_sweep();

    next_cycle();
    core_busy = 1'b1;
    repeat (3) key_exchange();
    random_access(20);
    read_sweep();
    next_cycle();

    $display(">>> PASS");
    $finish;
  end

endmodule

/* sources.f */
+incdir+design
design/shell_pkg.sv
design/sleep_ctrl.sv
design/key_mgr_fsm.sv
design/regfile_ff.sv
design/core_shell_top.sv
sim/tb_core_shell.sv

/* Makefile */
# Verilator build and run of the core shell testbench

VERILATOR ?= verilator
TOP       ?= tb_core_shell
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(wildcard design/*.sv design/*.svh sim/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG VFLAGS"

$(SIM): sources.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qxF '>>> PASS' $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
